/* source/sram_axi_consts.svh */
`ifndef SRAM_AXI_CONSTS_SVH
`define SRAM_AXI_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

`define SA_DATA_W 32
`define SA_ADDR_W 32
`define SA_ID_W 4

// Read client 0 is instruction and 1 is data
`define SA_READ_PORTS 2

//////////////////////////////////////////////////////////////////////
// Fixed burst shape
//////////////////////////////////////////////////////////////////////

`define SA_BURST_INCR 2'b01
`define SA_SIZE_WORD 3'b010

`endif

/* source/axi_types_pkg.sv */
`include "sram_axi_consts.svh"

package axi_types_pkg;

    typedef logic [`SA_ADDR_W-1:0] axi_addr_t;
    typedef logic [`SA_DATA_W-1:0] axi_data_t;
    typedef logic [`SA_ID_W-1:0]   axi_id_t;

    // Beats in the burst minus one
    typedef logic [7:0] axi_len_t;

    // Address channel payload, shared by AR and AW
    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
        logic [2:0] size;
        logic [1:0] burst;
    } ar_chan_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        logic      last;
    } r_chan_t;

    typedef struct packed {
        axi_data_t data;
        logic      last;
    } w_chan_t;

endpackage

/* source/sram_port_pkg.sv */
`include "sram_axi_consts.svh"

package sram_port_pkg;

    typedef logic [$clog2(`SA_READ_PORTS)-1:0] port_idx_t;

    // What a read engine asks the AR arbiter for
    typedef struct packed {
        axi_types_pkg::axi_addr_t addr;
        axi_types_pkg::axi_len_t  len;
    } rd_req_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_DATA,
        RD_DONE
    } rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_DONE
    } wr_state_e;

endpackage

/* source/read_engine.sv */
module read_engine (
    input  logic                     aclk,
    input  logic                     i_reset,
    input  axi_types_pkg::axi_addr_t i_raddr,
    input  axi_types_pkg::axi_len_t  i_rlen,
    input  logic                     i_rvalid,
    output logic                     o_rready,
    output axi_types_pkg::axi_data_t o_rdata,
    output logic                     o_req_valid,
    output sram_port_pkg::rd_req_t   o_req,
    input  logic                     i_grant,
    input  logic                     i_beat_valid,
    input  axi_types_pkg::r_chan_t   i_beat,
    output logic                     o_beat_ready
);

    sram_port_pkg::rd_state_e state_q;
    sram_port_pkg::rd_req_t   req_q;
    logic                     rready_q;
    axi_types_pkg::axi_data_t rdata_q;
    logic                     beat_fire;

    assign beat_fire = i_beat_valid && o_beat_ready;

    //////////////////////////////////////////////////////////////////////
    // Request FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            state_q  <= sram_port_pkg::RD_IDLE;
            rready_q <= 1'b0;
        end else begin
            // One client pulse per accepted beat
            rready_q <= beat_fire;
            unique case (state_q)
                sram_port_pkg::RD_IDLE: begin
                    if (i_rvalid) state_q <= sram_port_pkg::RD_REQ;
                end
                sram_port_pkg::RD_REQ: begin
                    if (i_grant) state_q <= sram_port_pkg::RD_DATA;
                end
                sram_port_pkg::RD_DATA: begin
                    if (beat_fire && i_beat.last) state_q <= sram_port_pkg::RD_DONE;
                end
                sram_port_pkg::RD_DONE: begin
                    // Held rvalid must not start another burst
                    if (!i_rvalid) state_q <= sram_port_pkg::RD_IDLE;
                end
                default: state_q <= sram_port_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state_q == sram_port_pkg::RD_IDLE && i_rvalid) begin
            req_q.addr <= i_raddr;
            req_q.len  <= i_rlen;
        end
        if (beat_fire) rdata_q <= i_beat.data;
    end

    assign o_req_valid  = (state_q == sram_port_pkg::RD_REQ);
    assign o_req        = req_q;
    assign o_beat_ready = (state_q == sram_port_pkg::RD_DATA);
    assign o_rready     = rready_q;
    assign o_rdata      = rdata_q;

endmodule

/* source/ar_arbiter.sv */
`include "sram_axi_consts.svh"

module ar_arbiter (
    input  logic                         aclk,
    input  logic                         i_reset,
    input  logic [`SA_READ_PORTS-1:0]    i_req_valid,
    input  sram_port_pkg::rd_req_t       i_req [`SA_READ_PORTS],
    output logic [`SA_READ_PORTS-1:0]    o_grant,
    output axi_types_pkg::ar_chan_t      o_ar,
    output logic                         o_ar_valid,
    input  logic                         i_ar_ready
);

    sram_port_pkg::port_idx_t last_q;
    sram_port_pkg::port_idx_t pick;
    logic                     pick_valid;
    axi_types_pkg::ar_chan_t  ar_q;
    logic                     ar_valid_q;
    logic                     load;

    // Search starts one past the last winner
    always_comb begin
        int unsigned idx;
        pick_valid = 1'b0;
        pick       = last_q;
        for (int k = 1; k <= `SA_READ_PORTS; k++) begin
            idx = (int'(last_q) + k) % `SA_READ_PORTS;
            if (!pick_valid && i_req_valid[idx]) begin
                pick_valid = 1'b1;
                pick       = sram_port_pkg::port_idx_t'(idx);
            end
        end
    end

    // Only an empty AR register takes a new request
    assign load = pick_valid && !ar_valid_q;

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            ar_valid_q <= 1'b0;
            last_q     <= '0;
        end else if (load) begin
            ar_valid_q <= 1'b1;
            last_q     <= pick;
        end else if (i_ar_ready) begin
            ar_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            ar_q.id    <= axi_types_pkg::axi_id_t'(pick);
            ar_q.addr  <= i_req[pick].addr;
            ar_q.len   <= i_req[pick].len;
            ar_q.size  <= `SA_SIZE_WORD;
            ar_q.burst <= `SA_BURST_INCR;
        end
    end

    // Grant goes to the owner of the ID in the cycle AR transfers
    always_comb begin
        o_grant = '0;
        o_grant[sram_port_pkg::port_idx_t'(ar_q.id)] = ar_valid_q && i_ar_ready;
    end

    assign o_ar       = ar_q;
    assign o_ar_valid = ar_valid_q;

endmodule

/* source/r_router.sv */
`include "sram_axi_consts.svh"

module r_router (
    input  axi_types_pkg::r_chan_t       i_r,
    input  logic                         i_r_valid,
    output logic                         o_r_ready,
    output logic [`SA_READ_PORTS-1:0]    o_beat_valid,
    output axi_types_pkg::r_chan_t       o_beat,
    input  logic [`SA_READ_PORTS-1:0]    i_beat_ready
);

    sram_port_pkg::port_idx_t dst;
    logic                     hit;

    // IDs past the engine count never match
    assign dst = sram_port_pkg::port_idx_t'(i_r.id);
    assign hit = (i_r.id < `SA_ID_W'(`SA_READ_PORTS));

    always_comb begin
        o_beat_valid      = '0;
        o_beat_valid[dst] = i_r_valid && hit;
    end

    assign o_r_ready = hit && i_beat_ready[dst];
    assign o_beat    = i_r;

endmodule

/* source/write_engine.sv */
`include "sram_axi_consts.svh"

module write_engine (
    input  logic                     aclk,
    input  logic                     i_reset,
    input  axi_types_pkg::axi_addr_t i_waddr,
    input  axi_types_pkg::axi_len_t  i_wlen,
    input  axi_types_pkg::axi_data_t i_wdata,
    input  logic                     i_wvalid,
    output logic                     o_wready,
    output axi_types_pkg::ar_chan_t  o_aw,
    output logic                     o_aw_valid,
    input  logic                     i_aw_ready,
    output axi_types_pkg::w_chan_t   o_w,
    output logic                     o_w_valid,
    input  logic                     i_w_ready,
    input  logic                     i_b_valid,
    output logic                     o_b_ready
);

    sram_port_pkg::wr_state_e state_q;
    axi_types_pkg::ar_chan_t  aw_q;
    axi_types_pkg::axi_len_t  beat_q;
    logic                     w_last;

    assign w_last = (beat_q == aw_q.len);

    //////////////////////////////////////////////////////////////////////
    // Burst FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            state_q <= sram_port_pkg::WR_IDLE;
            beat_q  <= '0;
        end else begin
            unique case (state_q)
                sram_port_pkg::WR_IDLE: begin
                    beat_q <= '0;
                    if (i_wvalid) state_q <= sram_port_pkg::WR_ADDR;
                end
                sram_port_pkg::WR_ADDR: begin
                    if (i_aw_ready) state_q <= sram_port_pkg::WR_DATA;
                end
                sram_port_pkg::WR_DATA: begin
                    if (i_w_ready) begin
                        beat_q <= beat_q + 8'd1;
                        if (w_last) state_q <= sram_port_pkg::WR_RESP;
                    end
                end
                sram_port_pkg::WR_RESP: begin
                    if (i_b_valid) state_q <= sram_port_pkg::WR_DONE;
                end
                sram_port_pkg::WR_DONE: begin
                    if (!i_wvalid) state_q <= sram_port_pkg::WR_IDLE;
                end
                default: state_q <= sram_port_pkg::WR_IDLE;
            endcase
        end
    end

    // Write ID is always zero
    always_ff @(posedge aclk) begin
        if (state_q == sram_port_pkg::WR_IDLE && i_wvalid) begin
            aw_q.id    <= '0;
            aw_q.addr  <= i_waddr;
            aw_q.len   <= i_wlen;
            aw_q.size  <= `SA_SIZE_WORD;
            aw_q.burst <= `SA_BURST_INCR;
        end
    end

    assign o_aw       = aw_q;
    assign o_aw_valid = (state_q == sram_port_pkg::WR_ADDR);
    assign o_w.data   = i_wdata;
    assign o_w.last   = w_last;
    assign o_w_valid  = (state_q == sram_port_pkg::WR_DATA);
    assign o_b_ready  = (state_q == sram_port_pkg::WR_RESP);

    // Per-word pulses, then the completion pulse with B
    assign o_wready = (o_w_valid && i_w_ready) || (o_b_ready && i_b_valid);

endmodule

/* source/sram_axi.sv */
`include "sram_axi_consts.svh"

module sram_axi (
    input  logic                     aclk,
    input  logic                     i_reset,
    // Instruction read client
    input  axi_types_pkg::axi_addr_t i_inst_raddr,
    input  axi_types_pkg::axi_len_t  i_inst_rlen,
    input  logic                     i_inst_rvalid,
    output logic                     o_inst_rready,
    output axi_types_pkg::axi_data_t o_inst_rdata,
    // Data read client
    input  axi_types_pkg::axi_addr_t i_data_raddr,
    input  axi_types_pkg::axi_len_t  i_data_rlen,
    input  logic                     i_data_rvalid,
    output logic                     o_data_rready,
    output axi_types_pkg::axi_data_t o_data_rdata,
    // Data write client
    input  axi_types_pkg::axi_addr_t i_data_waddr,
    input  axi_types_pkg::axi_len_t  i_data_wlen,
    input  axi_types_pkg::axi_data_t i_data_wdata,
    input  logic                     i_data_wvalid,
    output logic                     o_data_wready,
    // AXI4 master
    output axi_types_pkg::ar_chan_t  o_ar,
    output logic                     o_ar_valid,
    input  logic                     i_ar_ready,
    input  axi_types_pkg::r_chan_t   i_r,
    input  logic                     i_r_valid,
    output logic                     o_r_ready,
    output axi_types_pkg::ar_chan_t  o_aw,
    output logic                     o_aw_valid,
    input  logic                     i_aw_ready,
    output axi_types_pkg::w_chan_t   o_w,
    output logic                     o_w_valid,
    input  logic                     i_w_ready,
    input  logic                     i_b_valid,
    output logic                     o_b_ready
);

    axi_types_pkg::axi_addr_t  raddr [`SA_READ_PORTS];
    axi_types_pkg::axi_len_t   rlen  [`SA_READ_PORTS];
    axi_types_pkg::axi_data_t  rdata [`SA_READ_PORTS];
    sram_port_pkg::rd_req_t    req   [`SA_READ_PORTS];
    logic [`SA_READ_PORTS-1:0] rvalid;
    logic [`SA_READ_PORTS-1:0] rready;
    logic [`SA_READ_PORTS-1:0] req_valid;
    logic [`SA_READ_PORTS-1:0] grant;
    logic [`SA_READ_PORTS-1:0] beat_valid;
    logic [`SA_READ_PORTS-1:0] beat_ready;
    axi_types_pkg::r_chan_t    beat;

    //////////////////////////////////////////////////////////////////////
    // Engine 0 serves the instruction client
    //////////////////////////////////////////////////////////////////////

    assign raddr[0]      = i_inst_raddr;
    assign rlen[0]       = i_inst_rlen;
    assign rvalid[0]     = i_inst_rvalid;
    assign raddr[1]      = i_data_raddr;
    assign rlen[1]       = i_data_rlen;
    assign rvalid[1]     = i_data_rvalid;
    assign o_inst_rready = rready[0];
    assign o_inst_rdata  = rdata[0];
    assign o_data_rready = rready[1];
    assign o_data_rdata  = rdata[1];

    for (genvar p = 0; p < `SA_READ_PORTS; p++) begin : g_rd
        read_engine read_engine_i (
            .aclk         (aclk),
            .i_reset      (i_reset),
            .i_raddr      (raddr[p]),
            .i_rlen       (rlen[p]),
            .i_rvalid     (rvalid[p]),
            .o_rready     (rready[p]),
            .o_rdata      (rdata[p]),
            .o_req_valid  (req_valid[p]),
            .o_req        (req[p]),
            .i_grant      (grant[p]),
            .i_beat_valid (beat_valid[p]),
            .i_beat       (beat),
            .o_beat_ready (beat_ready[p])
        );
    end

    ar_arbiter ar_arbiter_i (
        .aclk        (aclk),
        .i_reset     (i_reset),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_grant     (grant),
        .o_ar        (o_ar),
        .o_ar_valid  (o_ar_valid),
        .i_ar_ready  (i_ar_ready)
    );

    r_router r_router_i (
        .i_r          (i_r),
        .i_r_valid    (i_r_valid),
        .o_r_ready    (o_r_ready),
        .o_beat_valid (beat_valid),
        .o_beat       (beat),
        .i_beat_ready (beat_ready)
    );

    write_engine write_engine_i (
        .aclk       (aclk),
        .i_reset    (i_reset),
        .i_waddr    (i_data_waddr),
        .i_wlen     (i_data_wlen),
        .i_wdata    (i_data_wdata),
        .i_wvalid   (i_data_wvalid),
        .o_wready   (o_data_wready),
        .o_aw       (o_aw),
        .o_aw_valid (o_aw_valid),
        .i_aw_ready (i_aw_ready),
        .o_w        (o_w),
        .o_w_valid  (o_w_valid),
        .i_w_ready  (i_w_ready),
        .i_b_valid  (i_b_valid),
        .o_b_ready  (o_b_ready)
    );

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
    output logic o_aclk
);

    // Period of 20 with the first rising edge at 10
    initial begin
        o_aclk = 1'b0;
        forever begin
            #10;
            o_aclk = ~o_aclk;
        end
    end

endmodule

/* testbench/axi_mem_model.sv */
module axi_mem_model (
    input  logic                    aclk,
    input  axi_types_pkg::ar_chan_t i_ar,
    input  logic                    i_ar_valid,
    output logic                    o_ar_ready,
    output axi_types_pkg::r_chan_t  o_r,
    output logic                    o_r_valid,
    input  logic                    i_r_ready,
    input  axi_types_pkg::ar_chan_t i_aw,
    input  logic                    i_aw_valid,
    output logic                    o_aw_ready,
    input  axi_types_pkg::w_chan_t  i_w,
    input  logic                    i_w_valid,
    output logic                    o_w_ready,
    output logic                    o_b_valid,
    input  logic                    i_b_ready
);

    localparam int unsigned MEM_WORDS = 16384;

    logic [31:0]             mem [MEM_WORDS];
    axi_types_pkg::ar_chan_t rd_q [$];
    int unsigned             r_beat;
    int unsigned             w_base;
    int unsigned             w_beat;
    int unsigned             ar_wait;
    int unsigned             r_wait;
    int unsigned             aw_wait;
    int unsigned             w_wait;
    int unsigned             b_wait;
    logic                    b_pending;

    function automatic int unsigned pick_delay();
        return $urandom % 4;
    endfunction

    // High once the countdown has run out
    function automatic logic delay_done(inout int unsigned cnt);
        if (cnt == 0) begin
            return 1'b1;
        end
        cnt--;
        return 1'b0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Handshakes seen at the rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic take_handshakes();
        if (i_ar_valid && o_ar_ready) begin
            rd_q.push_back(i_ar);
            ar_wait = pick_delay();
        end
        if (o_r_valid && i_r_ready) begin
            if (o_r.last) begin
                void'(rd_q.pop_front());
                r_beat = 0;
            end else begin
                r_beat++;
            end
            r_wait = pick_delay();
        end
        if (i_aw_valid && o_aw_ready) begin
            w_base  = 32'(i_aw.addr[15:2]);
            w_beat  = 0;
            aw_wait = pick_delay();
        end
        if (i_w_valid && o_w_ready) begin
            mem[(w_base + w_beat) % MEM_WORDS] = i_w.data;
            w_beat++;
            if (i_w.last) begin
                b_pending = 1'b1;
                b_wait    = pick_delay();
            end
            w_wait = pick_delay();
        end
        if (o_b_valid && i_b_ready) begin
            b_pending = 1'b0;
        end
    endtask

    // Outputs change on the falling edge only
    task automatic drive_outputs();
        logic r_free;
        o_ar_ready = delay_done(ar_wait);
        o_aw_ready = delay_done(aw_wait);
        o_w_ready  = delay_done(w_wait);
        o_b_valid  = b_pending && delay_done(b_wait);
        r_free     = delay_done(r_wait);
        if (r_free && rd_q.size() != 0) begin
            o_r_valid = 1'b1;
            o_r.id    = rd_q[0].id;
            o_r.data  = mem[(32'(rd_q[0].addr[15:2]) + r_beat) % MEM_WORDS];
            o_r.last  = (r_beat == 32'(rd_q[0].len));
        end else begin
            o_r_valid = 1'b0;
        end
    endtask

    initial begin
        // Word address XOR the fill constant
        for (int i = 0; i < int'(MEM_WORDS); i++) begin
            mem[i] = 32'(i) ^ 32'h5a5a0000;
        end
        o_ar_ready = 1'b0;
        o_r        = '0;
        o_r_valid  = 1'b0;
        o_aw_ready = 1'b0;
        o_w_ready  = 1'b0;
        o_b_valid  = 1'b0;
        r_beat     = 0;
        w_base     = 0;
        w_beat     = 0;
        ar_wait    = 0;
        r_wait     = 0;
        aw_wait    = 0;
        w_wait     = 0;
        b_wait     = 0;
        b_pending  = 1'b0;
        forever begin
            @(posedge aclk);
            take_handshakes();
            @(negedge aclk);
            drive_outputs();
        end
    end

endmodule

/* testbench/sram_axi_tb.sv */
module sram_axi_tb;

    localparam int TIMEOUT   = 1000;
    localparam int MEM_WORDS = 16384;

    logic                     aclk;
    logic                     reset;
    axi_types_pkg::axi_addr_t raddr [2];
    axi_types_pkg::axi_len_t  rlen [2];
    logic [1:0]               rvalid;
    logic [1:0]               rready;
    axi_types_pkg::axi_data_t rdata [2];
    axi_types_pkg::axi_addr_t waddr;
    axi_types_pkg::axi_len_t  wlen;
    axi_types_pkg::axi_data_t wdata;
    logic                     wvalid;
    logic                     wready;
    axi_types_pkg::ar_chan_t  ar;
    logic                     ar_valid;
    logic                     ar_ready;
    axi_types_pkg::r_chan_t   r;
    logic                     r_valid;
    logic                     r_ready;
    axi_types_pkg::ar_chan_t  aw;
    logic                     aw_valid;
    logic                     aw_ready;
    axi_types_pkg::w_chan_t   w;
    logic                     w_valid;
    logic                     w_ready;
    logic                     b_valid;
    logic                     b_ready;

    // Expected memory contents and the words of the next write burst
    logic [31:0] shadow [MEM_WORDS];
    logic [31:0] wr_buf [8];

    tb_clock clock_i (.o_aclk(aclk));

    sram_axi sram_axi_i (
        .aclk          (aclk),
        .i_reset       (reset),
        .i_inst_raddr  (raddr[0]),
        .i_inst_rlen   (rlen[0]),
        .i_inst_rvalid (rvalid[0]),
        .o_inst_rready (rready[0]),
        .o_inst_rdata  (rdata[0]),
        .i_data_raddr  (raddr[1]),
        .i_data_rlen   (rlen[1]),
        .i_data_rvalid (rvalid[1]),
        .o_data_rready (rready[1]),
        .o_data_rdata  (rdata[1]),
        .i_data_waddr  (waddr),
        .i_data_wlen   (wlen),
        .i_data_wdata  (wdata),
        .i_data_wvalid (wvalid),
        .o_data_wready (wready),
        .o_ar          (ar),
        .o_ar_valid    (ar_valid),
        .i_ar_ready    (ar_ready),
        .i_r           (r),
        .i_r_valid     (r_valid),
        .o_r_ready     (r_ready),
        .o_aw          (aw),
        .o_aw_valid    (aw_valid),
        .i_aw_ready    (aw_ready),
        .o_w           (w),
        .o_w_valid     (w_valid),
        .i_w_ready     (w_ready),
        .i_b_valid     (b_valid),
        .o_b_ready     (b_ready)
    );

    axi_mem_model mem_model_i (
        .aclk       (aclk),
        .i_ar       (ar),
        .i_ar_valid (ar_valid),
        .o_ar_ready (ar_ready),
        .o_r        (r),
        .o_r_valid  (r_valid),
        .i_r_ready  (r_ready),
        .i_aw       (aw),
        .i_aw_valid (aw_valid),
        .o_aw_ready (aw_ready),
        .i_w        (w),
        .i_w_valid  (w_valid),
        .o_w_ready  (w_ready),
        .o_b_valid  (b_valid),
        .i_b_ready  (b_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // Checks and client drivers
    //////////////////////////////////////////////////////////////////////

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("=== FAIL ===");
        $fatal(1, "stopped on a timeout");
    endtask

    function automatic logic [31:0] pattern_word(input int word_addr);
        return 32'(word_addr) ^ 32'h5a5a0000;
    endfunction

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge aclk);
            check_equal(32'({ar_valid, aw_valid, w_valid, b_ready, r_ready, rready, wready}),
                        32'd0, "idle outputs");
        end
    endtask

    // Every address handshake carries 4-byte beats and an INCR burst
    always @(posedge aclk) begin
        if (ar_valid && ar_ready) begin
            check_equal(32'(ar.size), 32'd2, "AR size");
            check_equal(32'(ar.burst), 32'd1, "AR burst");
        end
        if (aw_valid && aw_ready) begin
            check_equal(32'(aw.id), 32'd0, "AW id");
            check_equal(aw.addr, waddr, "AW address");
            check_equal(32'(aw.len), 32'(wlen), "AW len");
            check_equal(32'(aw.size), 32'd2, "AW size");
            check_equal(32'(aw.burst), 32'd1, "AW burst");
        end
    end

    // Port 0 is instruction and port 1 is data
    task automatic read_burst(input int port, input axi_types_pkg::axi_addr_t addr,
                              input axi_types_pkg::axi_len_t len, input int hold_cycles);
        int    beats;
        int    idle;
        int    base;
        string name;
        beats = 0;
        idle  = 0;
        base  = int'(addr[15:2]);
        name  = (port == 0) ? "inst read" : "data read";
        @(negedge aclk);
        raddr[port]  = addr;
        rlen[port]   = len;
        rvalid[port] = 1'b1;
        while (beats <= int'(len)) begin
            @(posedge aclk);
            if (rready[port]) begin
                check_equal(rdata[port], shadow[(base + beats) % MEM_WORDS],
                            $sformatf("%s beat %0d", name, beats));
                beats++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) fail_timeout({name, " beats"});
            end
        end
        // A held rvalid must not start a second burst
        repeat (hold_cycles) begin
            @(posedge aclk);
            check_equal(32'(rready[port]), 32'd0, {name, " pulse after the burst"});
        end
        @(negedge aclk);
        rvalid[port] = 1'b0;
    endtask

    task automatic write_burst(input axi_types_pkg::axi_addr_t addr,
                               input axi_types_pkg::axi_len_t len);
        int pulses;
        int idle;
        int base;
        pulses = 0;
        idle   = 0;
        base   = int'(addr[15:2]);
        @(negedge aclk);
        waddr  = addr;
        wlen   = len;
        wdata  = wr_buf[0];
        wvalid = 1'b1;
        // One pulse per word plus the completion pulse
        while (pulses < int'(len) + 2) begin
            @(posedge aclk);
            if (wready) begin
                pulses++;
                idle = 0;
                if (pulses <= int'(len)) begin
                    @(negedge aclk);
                    wdata = wr_buf[pulses];
                end
            end else begin
                idle++;
                if (idle > TIMEOUT) fail_timeout("write pulses");
            end
        end
        @(negedge aclk);
        wvalid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            shadow[(base + i) % MEM_WORDS] = wr_buf[i];
        end
        repeat (4) begin
            @(posedge aclk);
            check_equal(32'(wready), 32'd0, "write pulse after completion");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        reset = 1'b1;
        repeat (4) @(negedge aclk);
        reset = 1'b0;
    endtask

    task automatic test_idle_after_reset();
        expect_quiet(8);
    endtask

    task automatic test_inst_read();
        read_burst(0, 32'h0000_1000, 8'd15, 0);
        expect_quiet(10);
    endtask

    task automatic test_data_read_held();
        read_burst(1, 32'h0000_2040, 8'd2, 20);
    endtask

    task automatic test_parallel_reads();
        fork
            read_burst(0, 32'h0000_3000, 8'd5, 0);
            read_burst(1, 32'h0000_3400, 8'd7, 0);
        join
    endtask

    task automatic test_write_then_read();
        wr_buf[0] = 32'hdead_0001;
        wr_buf[1] = 32'hbeef_0002;
        wr_buf[2] = 32'hcafe_0003;
        wr_buf[3] = 32'hf00d_0004;
        write_burst(32'h0000_4000, 8'd3);
        read_burst(1, 32'h0000_4000, 8'd3, 0);
    endtask

    // Small window so reads often cover earlier writes
    task automatic test_random_rounds();
        axi_types_pkg::axi_addr_t inst_addr;
        axi_types_pkg::axi_addr_t data_addr;
        axi_types_pkg::axi_len_t  inst_len;
        axi_types_pkg::axi_len_t  data_len;
        for (int round = 0; round < 8; round++) begin
            for (int i = 0; i < 8; i++) begin
                wr_buf[i] = $urandom;
            end
            write_burst(32'h0000_5000 + 32'(($urandom % 64) * 4), 8'($urandom % 8));
            inst_addr = 32'h0000_5000 + 32'(($urandom % 64) * 4);
            data_addr = 32'h0000_5000 + 32'(($urandom % 64) * 4);
            inst_len  = 8'($urandom % 8);
            data_len  = 8'($urandom % 8);
            fork
                read_burst(0, inst_addr, inst_len, 0);
                read_burst(1, data_addr, data_len, 0);
            join
        end
    endtask

    initial begin
        void'($urandom(32'h481f));
        reset     = 1'b1;
        raddr[0]  = '0;
        raddr[1]  = '0;
        rlen[0]   = '0;
        rlen[1]   = '0;
        rvalid    = '0;
        waddr     = '0;
        wlen      = '0;
        wdata     = '0;
        wvalid    = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = pattern_word(i);
        end
        apply_reset();
        test_idle_after_reset();
        test_inst_read();
        test_data_read_held();
        test_parallel_reads();
        test_write_then_read();
        test_random_rounds();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* sources.f */
+incdir+source
source/axi_types_pkg.sv
source/sram_port_pkg.sv
source/read_engine.sv
source/ar_arbiter.sv
source/r_router.sv
source/write_engine.sv
source/sram_axi.sv
testbench/tb_clock.sv
testbench/axi_mem_model.sv
testbench/sram_axi_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= sram_axi_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
